// File: Bender.yml
package:
  name: spi_xip

dependencies: {}

sources:
  - files:
      - src/spi_pkg.sv
      - src/spi_apb_bridge.sv
      - src/spi_xip_sequencer.sv
      - src/spi_master_regs.sv
      - src/spi_shift_engine.sv
      - src/spi_xip_top.sv
  - target: test
    files:
      - tb/spi_xip_checker.sv
      - tb/spi_xip_tb.sv

// File: build.f
src/spi_pkg.sv
src/spi_apb_bridge.sv
src/spi_xip_sequencer.sv
src/spi_master_regs.sv
src/spi_shift_engine.sv
src/spi_xip_top.sv
tb/spi_xip_checker.sv
tb/spi_xip_tb.sv

// File: src/spi_apb_bridge.sv
`default_nettype none

module spi_apb_bridge (
  input  logic               clock,
  input  logic               reset,
  input  spi_pkg::apb_addr_t paddr_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  spi_pkg::apb_data_t pwdata_i,
  input  logic [3:0]         pstrb_i,
  input  logic [2:0]         pprot_i,
  output logic               pready_o,
  output spi_pkg::apb_data_t prdata_o,
  output logic               pslverr_o,
  output spi_pkg::reg_addr_t reg_adr_o,
  output spi_pkg::apb_data_t reg_wdata_o,
  output logic [3:0]         reg_sel_o,
  output logic               reg_we_o,
  output logic               reg_stb_o,
  input  spi_pkg::apb_data_t reg_rdata_i,
  input  logic               reg_ack_i,
  output logic               xip_start_o,
  output logic [23:0]        xip_addr_o,
  input  spi_pkg::reg_addr_t seq_adr_i,
  input  spi_pkg::apb_data_t seq_wdata_i,
  input  logic [3:0]         seq_sel_i,
  input  logic               seq_we_i,
  input  logic               seq_stb_i,
  input  logic               seq_done_i,
  input  spi_pkg::apb_data_t seq_rdata_i
);
  import spi_pkg::*;

  logic      hit_flash;
  logic      hit_regs;
  logic      accept;
  // Which window owns the current access
  logic      mode_reg;
  logic      mode_flash;
  logic      err_ack;
  // Pass-through request towards the register file
  logic      pass_stb;
  logic      pass_we;
  reg_addr_t pass_adr;
  apb_data_t pass_wdata;
  logic [3:0] pass_sel;

  assign hit_flash = (paddr_i >= FLASH_ADDR_START) && (paddr_i <= FLASH_ADDR_END);
  assign hit_regs  = (paddr_i >= SPI_MASTER_BASE) && (paddr_i <= SPI_MASTER_END);

  // New access only once the previous one has answered
  assign accept = psel_i && penable_i && !(mode_reg || mode_flash || err_ack);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mode_reg    <= 1'b0;
      mode_flash  <= 1'b0;
      err_ack     <= 1'b0;
      pass_stb    <= 1'b0;
      xip_start_o <= 1'b0;
    end else begin
      xip_start_o <= 1'b0;
      err_ack     <= 1'b0;
      if (accept) begin
        if (hit_regs) begin
          mode_reg <= 1'b1;
          pass_stb <= 1'b1;
        end else if (hit_flash && !pwrite_i) begin
          mode_flash  <= 1'b1;
          xip_start_o <= 1'b1;
        end else begin
          // Unmapped address or flash write
          err_ack <= 1'b1;
        end
      end
      if (mode_reg && reg_ack_i) begin
        mode_reg <= 1'b0;
        pass_stb <= 1'b0;
      end
      if (mode_flash && seq_done_i) begin
        mode_flash <= 1'b0;
      end
    end
  end

  // Request payload captured with the access
  always_ff @(posedge clock) begin
    if (accept) begin
      pass_adr   <= paddr_i[4:0];
      pass_wdata <= pwdata_i;
      pass_sel   <= pwrite_i ? pstrb_i : 4'hf;
      pass_we    <= pwrite_i;
      xip_addr_o <= paddr_i[23:0];
    end
  end

  // Sequencer owns the bus for the whole flash read
  assign reg_adr_o   = mode_flash ? seq_adr_i   : pass_adr;
  assign reg_wdata_o = mode_flash ? seq_wdata_i : pass_wdata;
  assign reg_sel_o   = mode_flash ? seq_sel_i   : pass_sel;
  assign reg_we_o    = mode_flash ? seq_we_i    : pass_we;
  assign reg_stb_o   = mode_flash ? seq_stb_i   : pass_stb;

  assign pready_o  = err_ack | (mode_reg & reg_ack_i) | (mode_flash & seq_done_i);
  assign pslverr_o = err_ack;
  assign prdata_o  = mode_flash ? seq_rdata_i : (mode_reg ? reg_rdata_i : '0);

endmodule

`default_nettype wire

// File: src/spi_master_regs.sv
`default_nettype none

module spi_master_regs (
  input  logic               clock,
  input  logic               reset,
  input  spi_pkg::reg_addr_t adr_i,
  input  spi_pkg::apb_data_t wdata_i,
  input  logic [3:0]         sel_i,
  input  logic               we_i,
  input  logic               stb_i,
  output spi_pkg::apb_data_t rdata_o,
  output logic               ack_o,
  output spi_pkg::shift_t    tx_data_o,
  output spi_pkg::char_len_t char_len_o,
  output spi_pkg::div_t      divider_o,
  output spi_pkg::ss_t       ss_o,
  output logic               go_o,
  input  spi_pkg::shift_t    rx_data_i,
  input  logic               done_i,
  output logic               irq_o
);
  import spi_pkg::*;

  apb_data_t tx0;
  apb_data_t tx1;
  logic      go_q;
  logic      ie_q;
  logic      int_flag;
  logic      access;
  logic      wr;

  // Byte lane merge
  function automatic apb_data_t lane_merge(apb_data_t old_v, apb_data_t new_v,
                                           logic [3:0] sel);
    apb_data_t res;
    res = old_v;
    for (int i = 0; i < 4; i++) begin
      if (sel[i]) res[i*8 +: 8] = new_v[i*8 +: 8];
    end
    return res;
  endfunction

  // First stb cycle before ack
  assign access = stb_i && !ack_o;
  // No writes while a transfer runs
  assign wr = access && we_i && !go_q;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ack_o      <= 1'b0;
      go_q       <= 1'b0;
      go_o       <= 1'b0;
      ie_q       <= 1'b0;
      int_flag   <= 1'b0;
      char_len_o <= '0;
      divider_o  <= '0;
      ss_o       <= '0;
    end else begin
      ack_o <= access;
      go_o  <= 1'b0;
      if (wr && adr_i == REG_CTRL) begin
        if (sel_i[0]) char_len_o <= wdata_i[5:0];
        if (sel_i[1]) begin
          ie_q <= wdata_i[CTRL_IE_BIT];
          go_q <= wdata_i[CTRL_GO_BIT];
          go_o <= wdata_i[CTRL_GO_BIT];
        end
      end
      if (wr && adr_i == REG_DIVIDER) begin
        divider_o <= div_t'(lane_merge(apb_data_t'(divider_o), wdata_i, sel_i));
      end
      if (wr && adr_i == REG_SS && sel_i[0]) begin
        ss_o <= wdata_i[SS_NUM-1:0];
      end
      // CTRL access acknowledges the interrupt
      if (access && adr_i == REG_CTRL) int_flag <= 1'b0;
      if (done_i) begin
        go_q     <= 1'b0;
        int_flag <= 1'b1;
      end
    end
  end

  // Data words and read return
  always_ff @(posedge clock) begin
    if (wr && adr_i == REG_DATA0) tx0 <= lane_merge(tx0, wdata_i, sel_i);
    if (wr && adr_i == REG_DATA1) tx1 <= lane_merge(tx1, wdata_i, sel_i);
    if (access) begin
      case (adr_i)
        REG_DATA0:   rdata_o <= rx_data_i[31:0];
        REG_DATA1:   rdata_o <= rx_data_i[63:32];
        REG_CTRL: begin
          rdata_o              <= apb_data_t'(char_len_o);
          rdata_o[CTRL_GO_BIT] <= go_q;
          rdata_o[CTRL_IE_BIT] <= ie_q;
        end
        REG_DIVIDER: rdata_o <= apb_data_t'(divider_o);
        REG_SS:      rdata_o <= apb_data_t'(ss_o);
        default:     rdata_o <= '0;
      endcase
    end
  end

  assign tx_data_o = {tx1, tx0};
  assign irq_o     = int_flag & ie_q;

endmodule

`default_nettype wire

// File: src/spi_pkg.sv
`default_nettype none

package spi_pkg;

  // Number of slave select lines
  localparam int SS_NUM = 8;

  // Bus and datapath widths
  typedef logic [31:0]       apb_addr_t;
  typedef logic [31:0]       apb_data_t;
  typedef logic [4:0]        reg_addr_t;
  typedef logic [SS_NUM-1:0] ss_t;
  // Zero encodes a 64 bit character
  typedef logic [5:0]        char_len_t;
  typedef logic [15:0]       div_t;
  typedef logic [63:0]       shift_t;

  // XIP sequencer states
  typedef enum logic [3:0] {
    IDLE,
    SEND_CMD,
    SEND_PAD,
    SET_DIVIDER,
    SET_SS,
    GO_BUSY,
    WAIT_COMPLETE,
    READ_DATA,
    DONE
  } xip_state_t;

  // Address windows on APB
  localparam apb_addr_t FLASH_ADDR_START = 32'h3000_0000;
  localparam apb_addr_t FLASH_ADDR_END   = 32'h3fff_ffff;
  localparam apb_addr_t SPI_MASTER_BASE  = 32'h1000_1000;
  localparam apb_addr_t SPI_MASTER_END   = 32'h1000_1fff;

  // Register offsets inside the SPI master
  localparam reg_addr_t REG_DATA0   = 5'h00;
  localparam reg_addr_t REG_DATA1   = 5'h04;
  localparam reg_addr_t REG_CTRL    = 5'h10;
  localparam reg_addr_t REG_DIVIDER = 5'h14;
  localparam reg_addr_t REG_SS      = 5'h18;

  // CTRL bit positions, CHAR_LEN sits in bits 5..0
  localparam int CTRL_GO_BIT = 8;
  localparam int CTRL_IE_BIT = 12;

  // Values the XIP sequencer programs
  localparam logic [7:0] FLASH_READ_CMD = 8'h03;
  localparam div_t       XIP_DIVIDER    = 16'd1;
  localparam ss_t        XIP_SS         = 8'h01;

endpackage

`default_nettype wire

// File: src/spi_shift_engine.sv
`default_nettype none

module spi_shift_engine (
  input  logic               clock,
  input  logic               reset,
  input  spi_pkg::shift_t    tx_data_i,
  input  spi_pkg::char_len_t char_len_i,
  input  spi_pkg::div_t      divider_i,
  input  spi_pkg::ss_t       ss_i,
  input  logic               go_i,
  output spi_pkg::shift_t    rx_data_o,
  output logic               busy_o,
  output logic               done_o,
  output logic               sclk_o,
  output logic               mosi_o,
  input  logic               miso_i,
  output spi_pkg::ss_t       ss_o
);
  import spi_pkg::*;

  div_t      cnt;
  logic [6:0] bit_cnt;
  logic [6:0] bit_len;
  char_len_t shift_amt;
  logic      start;
  logic      tick;
  logic      last_bit;
  shift_t    tx_sh;

  assign start = go_i && !busy_o;
  // End of an sclk half period
  assign tick = busy_o && (cnt == divider_i);
  // CHAR_LEN of 0 means 64
  assign bit_len  = {char_len_i == '0, char_len_i};
  assign last_bit = (bit_cnt == bit_len);
  // Places bit char_len-1 at the MSB
  assign shift_amt = -char_len_i;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy_o  <= 1'b0;
      done_o  <= 1'b0;
      sclk_o  <= 1'b0;
      cnt     <= '0;
      bit_cnt <= '0;
    end else begin
      done_o <= 1'b0;
      if (start) begin
        busy_o  <= 1'b1;
        sclk_o  <= 1'b0;
        cnt     <= '0;
        bit_cnt <= '0;
      end else if (tick) begin
        cnt <= '0;
        if (!sclk_o) begin
          sclk_o  <= 1'b1;
          bit_cnt <= bit_cnt + 7'd1;
        end else begin
          sclk_o <= 1'b0;
          if (last_bit) begin
            busy_o <= 1'b0;
            done_o <= 1'b1;
          end
        end
      end else if (busy_o) begin
        cnt <= cnt + 16'd1;
      end
    end
  end

  // Sample on rising edge, shift out on falling edge
  always_ff @(posedge clock) begin
    if (start) begin
      tx_sh     <= tx_data_i << shift_amt;
      rx_data_o <= '0;
    end else if (tick && !sclk_o) begin
      rx_data_o <= {rx_data_o[62:0], miso_i};
    end else if (tick && sclk_o && !last_bit) begin
      tx_sh <= {tx_sh[62:0], 1'b0};
    end
  end

  assign mosi_o = tx_sh[63];
  assign ss_o   = ~(ss_i & {SS_NUM{busy_o}});

endmodule

`default_nettype wire

// File: src/spi_xip_sequencer.sv
`default_nettype none

module spi_xip_sequencer (
  input  logic               clock,
  input  logic               reset,
  input  logic               start_i,
  input  logic [23:0]        flash_addr_i,
  output spi_pkg::reg_addr_t reg_adr_o,
  output spi_pkg::apb_data_t reg_wdata_o,
  output logic [3:0]         reg_sel_o,
  output logic               reg_we_o,
  output logic               reg_stb_o,
  input  spi_pkg::apb_data_t reg_rdata_i,
  input  logic               reg_ack_i,
  output spi_pkg::apb_data_t rdata_o,
  output logic               done_o
);
  import spi_pkg::*;

  xip_state_t state;
  xip_state_t next_state;

  // Access payload and successor for each state
  always_comb begin
    reg_adr_o   = REG_CTRL;
    reg_wdata_o = '0;
    reg_sel_o   = 4'hf;
    reg_we_o    = 1'b0;
    next_state  = state;
    case (state)
      SEND_CMD: begin
        // Opcode above the 24 bit offset goes out first
        reg_adr_o   = REG_DATA1;
        reg_wdata_o = {FLASH_READ_CMD, flash_addr_i};
        reg_we_o    = 1'b1;
        next_state  = SEND_PAD;
      end
      SEND_PAD: begin
        // Dummy low word while the flash answers
        reg_adr_o  = REG_DATA0;
        reg_we_o   = 1'b1;
        next_state = SET_DIVIDER;
      end
      SET_DIVIDER: begin
        reg_adr_o   = REG_DIVIDER;
        reg_wdata_o = apb_data_t'(XIP_DIVIDER);
        reg_we_o    = 1'b1;
        next_state  = SET_SS;
      end
      SET_SS: begin
        reg_adr_o   = REG_SS;
        reg_wdata_o = apb_data_t'(XIP_SS);
        reg_we_o    = 1'b1;
        next_state  = GO_BUSY;
      end
      GO_BUSY: begin
        // CHAR_LEN left at 0, i.e. 64 bits
        reg_wdata_o = apb_data_t'(1) << CTRL_GO_BIT;
        reg_we_o    = 1'b1;
        next_state  = WAIT_COMPLETE;
      end
      WAIT_COMPLETE: begin
        // Poll CTRL until GO drops
        next_state = reg_rdata_i[CTRL_GO_BIT] ? WAIT_COMPLETE : READ_DATA;
      end
      READ_DATA: begin
        reg_adr_o  = REG_DATA0;
        next_state = DONE;
      end
      default: begin
        next_state = state;
      end
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state     <= IDLE;
      reg_stb_o <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start_i) begin
            state <= SEND_CMD;
          end
        end
        DONE: begin
          state <= IDLE;
        end
        default: begin
          // Strobe held until ack, then one idle cycle
          if (reg_ack_i) begin
            reg_stb_o <= 1'b0;
            state     <= next_state;
          end else begin
            reg_stb_o <= 1'b1;
          end
        end
      endcase
    end
  end

  // Fetched flash word
  always_ff @(posedge clock) begin
    if (state == READ_DATA && reg_ack_i) begin
      rdata_o <= reg_rdata_i;
    end
  end

  assign done_o = (state == DONE);

endmodule

`default_nettype wire

// File: src/spi_xip_top.sv
`default_nettype none

module spi_xip_top (
  input  logic               clock,
  input  logic               reset,
  input  spi_pkg::apb_addr_t paddr_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  spi_pkg::apb_data_t pwdata_i,
  input  logic [3:0]         pstrb_i,
  input  logic [2:0]         pprot_i,
  output logic               pready_o,
  output spi_pkg::apb_data_t prdata_o,
  output logic               pslverr_o,
  output logic               sclk_o,
  output spi_pkg::ss_t       ss_o,
  output logic               mosi_o,
  input  logic               miso_i,
  output logic               irq_o
);
  import spi_pkg::*;

  // Register bus
  reg_addr_t  reg_adr;
  apb_data_t  reg_wdata;
  apb_data_t  reg_rdata;
  logic [3:0] reg_sel;
  logic       reg_we;
  logic       reg_stb;
  logic       reg_ack;
  // Sequencer request
  reg_addr_t  seq_adr;
  apb_data_t  seq_wdata;
  apb_data_t  seq_rdata;
  logic [3:0] seq_sel;
  logic       seq_we;
  logic       seq_stb;
  logic       seq_done;
  logic       xip_start;
  logic [23:0] xip_addr;
  // Register file to shift engine
  shift_t     tx_data;
  shift_t     rx_data;
  char_len_t  char_len;
  div_t       divider;
  ss_t        ss;
  logic       go_pulse;
  logic       done_pulse;

  spi_apb_bridge u_bridge (
    .clock, .reset,
    .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i, .pstrb_i, .pprot_i,
    .pready_o, .prdata_o, .pslverr_o,
    .reg_adr_o(reg_adr), .reg_wdata_o(reg_wdata), .reg_sel_o(reg_sel),
    .reg_we_o(reg_we), .reg_stb_o(reg_stb), .reg_rdata_i(reg_rdata), .reg_ack_i(reg_ack),
    .xip_start_o(xip_start), .xip_addr_o(xip_addr),
    .seq_adr_i(seq_adr), .seq_wdata_i(seq_wdata), .seq_sel_i(seq_sel), .seq_we_i(seq_we),
    .seq_stb_i(seq_stb), .seq_done_i(seq_done), .seq_rdata_i(seq_rdata)
  );

  spi_xip_sequencer u_seq (
    .clock, .reset,
    .start_i(xip_start), .flash_addr_i(xip_addr),
    .reg_adr_o(seq_adr), .reg_wdata_o(seq_wdata), .reg_sel_o(seq_sel),
    .reg_we_o(seq_we), .reg_stb_o(seq_stb), .reg_rdata_i(reg_rdata), .reg_ack_i(reg_ack),
    .rdata_o(seq_rdata), .done_o(seq_done)
  );

  spi_master_regs u_regs (
    .clock, .reset,
    .adr_i(reg_adr), .wdata_i(reg_wdata), .sel_i(reg_sel), .we_i(reg_we), .stb_i(reg_stb),
    .rdata_o(reg_rdata), .ack_o(reg_ack),
    .tx_data_o(tx_data), .char_len_o(char_len), .divider_o(divider), .ss_o(ss),
    .go_o(go_pulse), .rx_data_i(rx_data), .done_i(done_pulse), .irq_o
  );

  // Busy state is tracked by GO in the register file
  spi_shift_engine u_engine (
    .clock, .reset,
    .tx_data_i(tx_data), .char_len_i(char_len), .divider_i(divider), .ss_i(ss),
    .go_i(go_pulse), .rx_data_o(rx_data), .busy_o(), .done_o(done_pulse),
    .sclk_o, .mosi_o, .miso_i, .ss_o
  );

endmodule

`default_nettype wire

// File: tb/spi_xip_checker.sv
`default_nettype none

module spi_xip_checker (
  input logic         clock,
  input logic         reset,
  input logic         psel_i,
  input logic         penable_i,
  input logic         pready_i,
  input logic         pslverr_i,
  input logic         sclk_i,
  input spi_pkg::ss_t ss_i,
  input logic         mosi_i
);

  // Failed assertions so far
  int fail_count = 0;

  // Completion only inside an access phase
  ready_in_access: assert property (@(posedge clock) disable iff (reset)
    pready_i |-> (psel_i && penable_i))
    else begin
      $error("pready_o raised outside an APB access phase");
      fail_count++;
    end

  // No clock while every slave is deselected
  sclk_idle_low: assert property (@(posedge clock) disable iff (reset)
    (ss_i == '1) |-> !sclk_i)
    else begin
      $error("sclk_o toggles with no slave selected");
      fail_count++;
    end

  // Mode 0 data settles while sclk is low
  mosi_stable_high: assert property (@(posedge clock) disable iff (reset)
    (sclk_i && $past(sclk_i)) |-> $stable(mosi_i))
    else begin
      $error("mosi_o changed while sclk_o was high");
      fail_count++;
    end

  // Error answer completes one cycle into the access phase
  slverr_with_ready: assert property (@(posedge clock) disable iff (reset)
    pslverr_i |-> (pready_i && $past(psel_i && penable_i) &&
                   $past(psel_i && !penable_i, 2)))
    else begin
      $error("pslverr_o raised without pready_o or late in the access phase");
      fail_count++;
    end

endmodule

bind spi_xip_top spi_xip_checker u_checker (
  .clock(clock),
  .reset(reset),
  .psel_i(psel_i),
  .penable_i(penable_i),
  .pready_i(pready_o),
  .pslverr_i(pslverr_o),
  .sclk_i(sclk_o),
  .ss_i(ss_o),
  .mosi_i(mosi_o)
);

`default_nettype wire

// File: tb/spi_xip_tb.sv
`default_nettype none

module spi_xip_tb;
  import spi_pkg::*;

  localparam int N_XIP = 8;
  // Each XIP read shifts 64 bits, two half periods of divider+1 clocks per bit
  localparam int TIMEOUT_CYCLES = N_XIP * 64 * 2 * (int'(XIP_DIVIDER) + 1) + 2000;

  logic       clock;
  logic       reset;
  apb_addr_t  paddr;
  logic       psel;
  logic       penable;
  logic       pwrite;
  apb_data_t  pwdata;
  logic [3:0] pstrb;
  logic [2:0] pprot;
  logic       pready;
  apb_data_t  prdata;
  logic       pslverr;
  logic       sclk;
  ss_t        ss;
  logic       mosi;
  logic       miso;
  logic       irq;

  logic [31:0] lfsr_state;
  int          cycle_count;
  int          n;
  // Last APB response
  apb_data_t   rd_data;
  logic        rd_err;
  // Stimulus words
  apb_data_t   wdata;
  apb_data_t   tx_lo;
  apb_data_t   tx_hi;
  apb_addr_t   addr;
  // Flash model state
  int          bit_count;
  shift_t      mosi_bits;
  apb_data_t   flash_data;
  logic        miso_next;
  logic        ss0_seen_low;
  ss_t         ss_expect;

  spi_xip_top dut0 (
    .clock(clock), .reset(reset),
    .paddr_i(paddr), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .pwdata_i(pwdata), .pstrb_i(pstrb), .pprot_i(pprot),
    .pready_o(pready), .prdata_o(prdata), .pslverr_o(pslverr),
    .sclk_o(sclk), .ss_o(ss), .mosi_o(mosi), .miso_i(miso), .irq_o(irq)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Flash contents, offset scrambled then rotated by its own low bits
  function automatic apb_data_t flash_word(input logic [23:0] offset);
    apb_data_t x;
    int i;
    x = {8'h00, offset} ^ 32'h5a5a_5a5a;
    for (i = 0; i < int'(offset[4:0]); i++) begin
      x = {x[30:0], x[31]};
    end
    return x;
  endfunction

  // Galois LFSR, one step per bit taken
  function automatic apb_data_t random_bits(input int count);
    apb_data_t value;
    int i;
    value = '0;
    for (i = 0; i < count; i++) begin
      value = {value[30:0], lfsr_state[0]};
      if (lfsr_state[0]) lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      else lfsr_state = lfsr_state >> 1;
    end
    return value;
  endfunction

  task automatic check_data(input string name, input apb_data_t expected,
                            input apb_data_t actual);
    if (actual !== expected) begin
      $display("Error %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("Verification failed");
      $fatal(1, "Data mismatch on %s", name);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error %s expected 0x%h actual 0x%h", name, expected, actual);
      $display("Verification failed");
      $fatal(1, "Bit mismatch on %s", name);
    end
  endtask

  task automatic check_ss(input string name, input ss_t expected, input ss_t actual);
    if (actual !== expected) begin
      $display("Error %s expected 0x%02h actual 0x%02h", name, expected, actual);
      $display("Verification failed");
      $fatal(1, "Slave select mismatch on %s", name);
    end
  endtask

  // Setup, access, wait for pready, release after the completing edge
  task automatic apb_transfer(input logic write, input apb_addr_t a, input apb_data_t d);
    @(negedge clock);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = a;
    pwdata  = d;
    pstrb   = 4'hf;
    @(negedge clock);
    penable = 1'b1;
    @(negedge clock);
    while (!pready) @(negedge clock);
    rd_data = prdata;
    rd_err  = pslverr;
    @(negedge clock);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t a, input apb_data_t d);
    apb_transfer(1'b1, a, d);
  endtask

  task automatic apb_read(input apb_addr_t a);
    apb_transfer(1'b0, a, '0);
  endtask

  // New command on every falling select, miso quiet during the command
  always @(negedge ss[0]) begin
    bit_count    = 0;
    ss0_seen_low = 1'b1;
    @(negedge clock);
    miso = 1'b0;
  end

  // Sample mosi on rising sclk, look up the word after 32 command bits
  always @(posedge sclk) begin
    if (!ss[0]) begin
      check_ss("ss_o", ss_expect, ss);
      mosi_bits = {mosi_bits[62:0], mosi};
      bit_count++;
      if (bit_count == 32) flash_data = flash_word(mosi_bits[23:0]);
    end
  end

  // Data MSB first, moved after falling sclk
  always @(negedge sclk) begin
    if (!ss[0] && bit_count >= 32 && bit_count < 64) begin
      miso_next = flash_data[63 - bit_count];
      @(negedge clock);
      miso = miso_next;
    end
  end

  // Run limit
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Verification failed");
    $fatal(1, "Timeout");
  end

  initial begin
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    pstrb      = 4'h0;
    pprot      = 3'b000;
    miso       = 1'b0;
    lfsr_state = 32'ha18aad9f;
    ss_expect  = 8'hfe;
    reset      = 1'b1;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    // Register round trip
    wdata = random_bits(32);
    apb_write(SPI_MASTER_BASE + REG_DIVIDER, wdata);
    check_bit("pslverr_o", 1'b0, rd_err);
    apb_read(SPI_MASTER_BASE + REG_DIVIDER);
    check_bit("pslverr_o", 1'b0, rd_err);
    check_data("prdata_o", {16'h0, wdata[15:0]}, rd_data);
    wdata = random_bits(32);
    apb_write(SPI_MASTER_BASE + REG_SS, wdata);
    check_bit("pslverr_o", 1'b0, rd_err);
    apb_read(SPI_MASTER_BASE + REG_SS);
    check_bit("pslverr_o", 1'b0, rd_err);
    check_data("prdata_o", {24'h0, wdata[7:0]}, rd_data);

    // XIP reads at random flash offsets
    for (n = 0; n < N_XIP; n++) begin
      addr         = FLASH_ADDR_START | random_bits(28);
      ss0_seen_low = 1'b0;
      apb_read(addr);
      check_bit("pslverr_o", 1'b0, rd_err);
      check_data("prdata_o", flash_word(addr[23:0]), rd_data);
      check_bit("ss_o[0] low", 1'b1, ss0_seen_low);
      check_data("flash command", {FLASH_READ_CMD, addr[23:0]}, mosi_bits[63:32]);
    end

    // Manual 64 bit transfer, slow clock
    tx_lo = random_bits(32);
    tx_hi = random_bits(32);
    apb_write(SPI_MASTER_BASE + REG_DATA0, tx_lo);
    apb_write(SPI_MASTER_BASE + REG_DATA1, tx_hi);
    apb_write(SPI_MASTER_BASE + REG_DIVIDER, 32'd3);
    apb_write(SPI_MASTER_BASE + REG_SS, 32'h01);
    apb_write(SPI_MASTER_BASE + REG_CTRL, 32'h1 << CTRL_GO_BIT);
    apb_read(SPI_MASTER_BASE + REG_CTRL);
    while (rd_data[CTRL_GO_BIT]) apb_read(SPI_MASTER_BASE + REG_CTRL);
    check_data("mosi bits high", tx_hi, mosi_bits[63:32]);
    check_data("mosi bits low", tx_lo, mosi_bits[31:0]);
    apb_read(SPI_MASTER_BASE + REG_DATA0);
    check_data("prdata_o", flash_word(tx_hi[23:0]), rd_data);
    apb_read(SPI_MASTER_BASE + REG_DATA1);
    check_data("prdata_o", 32'h0, rd_data);

    // Interrupt on completion, cleared by a CTRL read
    apb_write(SPI_MASTER_BASE + REG_CTRL,
              (32'h1 << CTRL_IE_BIT) | (32'h1 << CTRL_GO_BIT) | 32'd8);
    check_bit("irq_o", 1'b0, irq);
    while (!irq) @(negedge clock);
    apb_read(SPI_MASTER_BASE + REG_CTRL);
    check_bit("CTRL GO", 1'b0, rd_data[CTRL_GO_BIT]);
    check_bit("CTRL IE", 1'b1, rd_data[CTRL_IE_BIT]);
    check_bit("irq_o", 1'b0, irq);

    // Decode errors leave the registers alone
    tx_lo = random_bits(16);
    tx_hi = random_bits(8);
    apb_write(SPI_MASTER_BASE + REG_DIVIDER, tx_lo);
    apb_write(SPI_MASTER_BASE + REG_SS, tx_hi);
    apb_write(SPI_MASTER_END + 1 + REG_DIVIDER, random_bits(32));
    check_bit("pslverr_o", 1'b1, rd_err);
    apb_read(SPI_MASTER_END + 1 + REG_SS);
    check_bit("pslverr_o", 1'b1, rd_err);
    apb_write(FLASH_ADDR_START + REG_DIVIDER, random_bits(32));
    check_bit("pslverr_o", 1'b1, rd_err);
    apb_read(SPI_MASTER_BASE + REG_DIVIDER);
    check_data("prdata_o", {16'h0, tx_lo[15:0]}, rd_data);
    apb_read(SPI_MASTER_BASE + REG_SS);
    check_data("prdata_o", {24'h0, tx_hi[7:0]}, rd_data);

    if (dut0.u_checker.fail_count == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Protocol assertions failed %0d times", dut0.u_checker.fail_count);
      $display("Verification failed");
      $fatal(1, "Assertion failures");
    end
  end

endmodule

`default_nettype wire
